// ==== design/mrd_ctrl_fsm.sv ====
// DFT control FSM: walks bins and samples, steps the core and writes results to the bank
`timescale 1ns/10ps
`include "mrd_cfg.svh"

module mrd_ctrl_fsm (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  frame_ready,
	input  mrd_pkg::mrd_radix_e   radix,
	input  logic                  out_busy,
	output logic                  frame_taken,
	output logic [`MRD_IDX_W-1:0] rd_idx,
	output logic [`MRD_IDX_W-1:0] tw_idx,
	output logic                  acc_clr,
	output logic                  acc_en,
	output logic                  bin_wr,
	output logic [`MRD_IDX_W-1:0] wr_idx,
	output logic                  out_start
);
	import mrd_pkg::*;

	localparam int IDX_W = `MRD_IDX_W;

	mrd_state_e       state;
	logic             pend;
	logic [IDX_W-1:0] n_pts;
	logic [IDX_W-1:0] k;
	logic [IDX_W-1:0] n;
	logic [IDX_W-1:0] nk;
	logic [IDX_W:0]   nk_sum;
	logic [IDX_W:0]   nk_wrap;
	logic [IDX_W-1:0] nk_next;

	assign frame_taken = (state == ST_IDLE) && pend && !out_busy;
	assign rd_idx = n;

	// n*k mod N grows by k for every sample
	assign nk_sum = {1'b0, nk} + {1'b0, k};
	assign nk_wrap = nk_sum - {1'b0, n_pts};
	assign nk_next = (nk_sum >= {1'b0, n_pts}) ? nk_wrap[IDX_W-1:0] : nk_sum[IDX_W-1:0];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			pend <= 1'b0;
			n_pts <= '0;
			k <= '0;
			n <= '0;
			nk <= '0;
			acc_en <= 1'b0;
			acc_clr <= 1'b0;
			bin_wr <= 1'b0;
			out_start <= 1'b0;
		end
		else
		begin
			if (frame_ready)
				pend <= 1'b1;
			else if (frame_taken)
				pend <= 1'b0;
			// core and bank controls lag one cycle behind the read index
			acc_en <= (state == ST_MAC);
			acc_clr <= (state == ST_MAC) && (n == '0);
			bin_wr <= (state == ST_WRITE);
			out_start <= (state == ST_WRITE) && (k == n_pts - 1'b1);
			case (state)
				ST_IDLE:
				begin
					if (frame_taken)
					begin
						n_pts <= rdx_pts(radix);
						k <= '0;
						n <= '0;
						nk <= '0;
						state <= ST_MAC;
					end
				end
				ST_MAC:
				begin
					if (n == n_pts - 1'b1)
						state <= ST_WRITE;
					else
					begin
						n <= n + 1'b1;
						nk <= nk_next;
					end
				end
				ST_WRITE:
				begin
					if (k == n_pts - 1'b1)
						state <= ST_WAIT_OUT;
					else
					begin
						k <= k + 1'b1;
						n <= '0;
						nk <= '0;
						state <= ST_MAC;
					end
				end
				default:
				begin
					// out_busy rises one cycle after out_start
					if (!out_busy && !out_start)
						state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		tw_idx <= nk;
		wr_idx <= k;
	end

endmodule

// ==== design/mrd_mem.sv ====
// DFT memory block: input sample bank with frame checking, result bank and output stream
`timescale 1ns/10ps
`include "mrd_cfg.svh"

module mrd_mem (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         sink_valid,
	output logic                         sink_ready,
	input  logic                         sink_sop,
	input  logic                         sink_eop,
	input  logic signed [`MRD_IN_W-1:0]  sink_real,
	input  logic signed [`MRD_IN_W-1:0]  sink_imag,
	input  logic [`MRD_PTS_W-1:0]        dftpts_in,
	input  logic                         inverse,
	output logic                         source_valid,
	input  logic                         source_ready,
	output logic                         source_sop,
	output logic                         source_eop,
	output logic signed [`MRD_OUT_W-1:0] source_real,
	output logic signed [`MRD_OUT_W-1:0] source_imag,
	output logic [`MRD_PTS_W-1:0]        dftpts_out,
	input  logic                         frame_taken,
	output logic                         frame_ready,
	output mrd_pkg::mrd_radix_e          radix,
	output logic                         frame_inverse,
	input  logic [`MRD_IDX_W-1:0]        rd_idx,
	output logic signed [`MRD_IN_W-1:0]  rd_real,
	output logic signed [`MRD_IN_W-1:0]  rd_imag,
	input  logic                         bin_wr,
	input  logic [`MRD_IDX_W-1:0]        wr_idx,
	input  logic signed [`MRD_OUT_W-1:0] bin_real,
	input  logic signed [`MRD_OUT_W-1:0] bin_imag,
	input  logic                         out_start,
	output logic                         out_busy
);
	import mrd_pkg::*;

	localparam int PTS_W = `MRD_PTS_W;
	localparam int IDX_W = `MRD_IDX_W;

	logic signed [`MRD_IN_W-1:0]  in_re  [`MRD_MAX_PTS];
	logic signed [`MRD_IN_W-1:0]  in_im  [`MRD_MAX_PTS];
	logic signed [`MRD_IN_W-1:0]  cmp_re [`MRD_MAX_PTS];
	logic signed [`MRD_IN_W-1:0]  cmp_im [`MRD_MAX_PTS];
	logic signed [`MRD_OUT_W-1:0] res_re [`MRD_MAX_PTS];
	logic signed [`MRD_OUT_W-1:0] res_im [`MRD_MAX_PTS];

	logic             in_frame;
	logic             in_full;
	logic [IDX_W-1:0] in_cnt;
	logic [IDX_W-1:0] in_ptr;
	logic [IDX_W-1:0] in_last;
	logic [IDX_W-1:0] out_cnt;
	logic [IDX_W-1:0] out_last;
	mrd_radix_e       sop_radix;
	mrd_radix_e       in_radix;
	mrd_radix_e       cmp_radix;
	logic             in_inv;
	logic             cmp_inv;
	logic [PTS_W-1:0] in_pts;
	logic [PTS_W-1:0] cmp_pts;
	logic             sink_xfer;
	logic             src_xfer;

	assign sink_ready = !in_full;
	assign sink_xfer = sink_valid && sink_ready;
	assign src_xfer = source_valid && source_ready;
	assign in_ptr = sink_sop ? '0 : in_cnt;
	assign in_last = rdx_pts(in_radix) - 1'b1;
	assign out_last = rdx_pts(cmp_radix) - 1'b1;
	assign out_busy = source_valid;

	// the waiting frame shows through in the cycle it is taken
	assign radix = frame_taken ? in_radix : cmp_radix;
	assign frame_inverse = frame_taken ? in_inv : cmp_inv;

	always_comb
	begin
		case (dftpts_in)
			PTS_W'(2): sop_radix = RDX_2;
			PTS_W'(3): sop_radix = RDX_3;
			PTS_W'(4): sop_radix = RDX_4;
			PTS_W'(5): sop_radix = RDX_5;
			default:   sop_radix = RDX_BAD;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (sink_xfer)
		begin
			in_re[in_ptr] <= sink_real;
			in_im[in_ptr] <= sink_imag;
		end
		if (sink_xfer && sink_sop)
		begin
			in_radix <= sop_radix;
			in_inv <= inverse;
			in_pts <= dftpts_in;
		end
		// the compute copy frees the input bank for the next frame
		if (frame_taken)
		begin
			cmp_re <= in_re;
			cmp_im <= in_im;
			cmp_radix <= in_radix;
			cmp_inv <= in_inv;
			cmp_pts <= in_pts;
		end
		rd_real <= cmp_re[rd_idx];
		rd_imag <= cmp_im[rd_idx];
		if (bin_wr)
		begin
			res_re[wr_idx] <= bin_real;
			res_im[wr_idx] <= bin_imag;
		end
		if (out_start)
		begin
			source_real <= res_re[0];
			source_imag <= res_im[0];
			dftpts_out <= cmp_pts;
		end
		else if (src_xfer && !source_eop)
		begin
			source_real <= res_re[out_cnt];
			source_imag <= res_im[out_cnt];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			in_frame <= 1'b0;
			in_full <= 1'b0;
			in_cnt <= '0;
			frame_ready <= 1'b0;
			source_valid <= 1'b0;
			source_sop <= 1'b0;
			source_eop <= 1'b0;
			out_cnt <= '0;
		end
		else
		begin
			frame_ready <= 1'b0;
			if (frame_taken)
				in_full <= 1'b0;
			if (sink_xfer && sink_sop)
			begin
				// a bad count or an eop on the first sample drops the frame
				in_frame <= (sop_radix != RDX_BAD) && !sink_eop;
				in_cnt <= IDX_W'(1);
			end
			else if (sink_xfer && in_frame)
			begin
				in_cnt <= in_cnt + 1'b1;
				if (sink_eop || in_cnt == in_last)
					in_frame <= 1'b0;
				if (sink_eop && in_cnt == in_last)
				begin
					in_full <= 1'b1;
					frame_ready <= 1'b1;
				end
			end
			if (out_start)
			begin
				source_valid <= 1'b1;
				source_sop <= 1'b1;
				source_eop <= 1'b0;
				out_cnt <= IDX_W'(1);
			end
			else if (src_xfer)
			begin
				source_sop <= 1'b0;
				source_eop <= (out_cnt == out_last);
				if (source_eop)
					source_valid <= 1'b0;
				out_cnt <= out_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== design/mrd_pkg.sv ====
// mixed radix DFT shared types: control states, radix codes and their point counts
`include "mrd_cfg.svh"

package mrd_pkg;

	// radix of the current frame, decoded from the point count at sop
	typedef enum logic [2:0]
	{
		RDX_2,
		RDX_3,
		RDX_4,
		RDX_5,
		RDX_BAD
	} mrd_radix_e;

	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_MAC,
		ST_WRITE,
		ST_WAIT_OUT
	} mrd_state_e;

	// number of points for a radix, zero when the frame is illegal
	function automatic logic [`MRD_IDX_W-1:0] rdx_pts(input mrd_radix_e radix);
		case (radix)
			RDX_2:   return `MRD_IDX_W'(2);
			RDX_3:   return `MRD_IDX_W'(3);
			RDX_4:   return `MRD_IDX_W'(4);
			RDX_5:   return `MRD_IDX_W'(5);
			default: return '0;
		endcase
	endfunction

endpackage

// ==== design/mrd_rdx2345_core.sv ====
// radix 2/3/4/5 DFT core: constant twiddle table and complex multiply-accumulate per bin
`timescale 1ns/10ps
`include "mrd_cfg.svh"

module mrd_rdx2345_core (
	input  logic                         clk,
	input  logic                         rst,
	input  mrd_pkg::mrd_radix_e          radix,
	input  logic                         frame_inverse,
	input  logic [`MRD_IDX_W-1:0]        tw_idx,
	input  logic                         acc_clr,
	input  logic                         acc_en,
	input  logic signed [`MRD_IN_W-1:0]  rd_real,
	input  logic signed [`MRD_IN_W-1:0]  rd_imag,
	output logic signed [`MRD_OUT_W-1:0] bin_real,
	output logic signed [`MRD_OUT_W-1:0] bin_imag
);
	import mrd_pkg::*;

	localparam int TW_W = `MRD_TW_W;
	localparam int IDX_W = `MRD_IDX_W;
	localparam int PROD_W = `MRD_IN_W + `MRD_TW_W;

	// rounded cos and sin magnitudes for the 120 and 72 degree steps
	localparam logic signed [TW_W-1:0] ONE = `MRD_TW_ONE;
	localparam logic signed [TW_W-1:0] ZERO = 0;
	localparam logic signed [TW_W-1:0] C3 = 8192;
	localparam logic signed [TW_W-1:0] S3 = 14189;
	localparam logic signed [TW_W-1:0] C5A = 5063;
	localparam logic signed [TW_W-1:0] S5A = 15582;
	localparam logic signed [TW_W-1:0] C5B = 13255;
	localparam logic signed [TW_W-1:0] S5B = 9630;

	logic signed [TW_W-1:0]       tw_cos;
	logic signed [TW_W-1:0]       tw_sin;
	logic signed [TW_W-1:0]       tw_s;
	logic signed [PROD_W-1:0]     prod_ac;
	logic signed [PROD_W-1:0]     prod_bs;
	logic signed [PROD_W-1:0]     prod_as;
	logic signed [PROD_W-1:0]     prod_bc;
	logic signed [`MRD_ACC_W-1:0] mac_re;
	logic signed [`MRD_ACC_W-1:0] mac_im;
	logic signed [`MRD_ACC_W-1:0] acc_re;
	logic signed [`MRD_ACC_W-1:0] acc_im;
	logic signed [`MRD_ACC_W-1:0] sh_re;
	logic signed [`MRD_ACC_W-1:0] sh_im;

	// cos and sin of 2*pi*m/N, index zero of every radix falls to the default
	always_comb
	begin
		case ({radix, tw_idx})
			{RDX_2, IDX_W'(1)}: {tw_cos, tw_sin} = {-ONE, ZERO};
			{RDX_3, IDX_W'(1)}: {tw_cos, tw_sin} = {-C3, S3};
			{RDX_3, IDX_W'(2)}: {tw_cos, tw_sin} = {-C3, -S3};
			{RDX_4, IDX_W'(1)}: {tw_cos, tw_sin} = {ZERO, ONE};
			{RDX_4, IDX_W'(2)}: {tw_cos, tw_sin} = {-ONE, ZERO};
			{RDX_4, IDX_W'(3)}: {tw_cos, tw_sin} = {ZERO, -ONE};
			{RDX_5, IDX_W'(1)}: {tw_cos, tw_sin} = {C5A, S5A};
			{RDX_5, IDX_W'(2)}: {tw_cos, tw_sin} = {-C5B, S5B};
			{RDX_5, IDX_W'(3)}: {tw_cos, tw_sin} = {-C5B, -S5B};
			{RDX_5, IDX_W'(4)}: {tw_cos, tw_sin} = {C5A, -S5A};
			default:            {tw_cos, tw_sin} = {ONE, ZERO};
		endcase
	end

	// forward transform rotates the other way
	assign tw_s = frame_inverse ? tw_sin : -tw_sin;

	assign prod_ac = rd_real * tw_cos;
	assign prod_bs = rd_imag * tw_s;
	assign prod_as = rd_real * tw_s;
	assign prod_bc = rd_imag * tw_cos;
	assign mac_re = prod_ac - prod_bs;
	assign mac_im = prod_as + prod_bc;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			acc_re <= '0;
			acc_im <= '0;
		end
		else if (acc_en)
		begin
			acc_re <= acc_clr ? mac_re : acc_re + mac_re;
			acc_im <= acc_clr ? mac_im : acc_im + mac_im;
		end
	end

	assign sh_re = acc_re >>> `MRD_OUT_SHIFT;
	assign sh_im = acc_im >>> `MRD_OUT_SHIFT;
	assign bin_real = sh_re[`MRD_OUT_W-1:0];
	assign bin_imag = sh_im[`MRD_OUT_W-1:0];

endmodule

// ==== design/mrd_top.sv ====
// mixed radix DFT engine top: stream ports around the sample banks, radix core and control FSM
`timescale 1ns/10ps
`include "mrd_cfg.svh"

module mrd_top (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         sink_valid,
	output logic                         sink_ready,
	input  logic                         sink_sop,
	input  logic                         sink_eop,
	input  logic signed [`MRD_IN_W-1:0]  sink_real,
	input  logic signed [`MRD_IN_W-1:0]  sink_imag,
	input  logic [`MRD_PTS_W-1:0]        dftpts_in,
	input  logic                         inverse,
	output logic                         source_valid,
	input  logic                         source_ready,
	output logic                         source_sop,
	output logic                         source_eop,
	output logic signed [`MRD_OUT_W-1:0] source_real,
	output logic signed [`MRD_OUT_W-1:0] source_imag,
	output logic [`MRD_PTS_W-1:0]        dftpts_out
);
	import mrd_pkg::*;

	// frame handoff between the banks and the FSM
	logic       frame_ready;
	logic       frame_taken;
	mrd_radix_e radix;
	logic       frame_inverse;
	logic       out_start;
	logic       out_busy;

	// sample read and result write paths
	logic [`MRD_IDX_W-1:0]        rd_idx;
	logic signed [`MRD_IN_W-1:0]  rd_real;
	logic signed [`MRD_IN_W-1:0]  rd_imag;
	logic [`MRD_IDX_W-1:0]        tw_idx;
	logic                         acc_clr;
	logic                         acc_en;
	logic signed [`MRD_OUT_W-1:0] bin_real;
	logic signed [`MRD_OUT_W-1:0] bin_imag;
	logic                         bin_wr;
	logic [`MRD_IDX_W-1:0]        wr_idx;

	mrd_mem u_mem (.*);

	mrd_rdx2345_core u_core (.*);

	mrd_ctrl_fsm u_ctrl (.*);

endmodule

// ==== include/mrd_cfg.svh ====
// mixed radix DFT configuration: data widths, bank depth and twiddle scaling
`ifndef MRD_CFG_SVH
`define MRD_CFG_SVH

// sample, result and point-count field widths
`define MRD_IN_W      18
`define MRD_OUT_W     30
`define MRD_PTS_W     12

// the largest radix sets the bank depth and the index width
`define MRD_MAX_PTS   5
`define MRD_IDX_W     3

// twiddles are signed with unity at 16384
`define MRD_TW_W      16
`define MRD_TW_ONE    16384

// accumulator width and the shift that scales it down to a result
`define MRD_ACC_W     37
`define MRD_OUT_SHIFT 7

`endif

// ==== mrd_top.f ====
+incdir+include
design/mrd_pkg.sv
design/mrd_mem.sv
design/mrd_rdx2345_core.sv
design/mrd_ctrl_fsm.sv
design/mrd_top.sv
verif/mrd_sva.sv
verif/mrd_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the DFT engine testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module mrd_tb -f mrd_top.f \
	--Mdir obj_dir -o mrd_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/mrd_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -qx "Simulation PASSED" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== verif/mrd_sva.sv ====
// DFT engine stream assertions on output hold, frame markers, input stall and the idle handoff
`timescale 1ns/10ps
`include "mrd_cfg.svh"

module mrd_sva (
	input logic                         clk,
	input logic                         rst,
	input logic                         sink_ready,
	input logic                         source_valid,
	input logic                         source_ready,
	input logic                         source_sop,
	input logic                         source_eop,
	input logic signed [`MRD_OUT_W-1:0] source_real,
	input logic signed [`MRD_OUT_W-1:0] source_imag,
	input logic [`MRD_PTS_W-1:0]        dftpts_out,
	input logic                         frame_taken,
	input mrd_pkg::mrd_state_e          ctrl_state
);
	import mrd_pkg::*;

	int fail_cnt = 0;

	// a stalled output beat keeps its data and markers until the sink takes it
	a_hold: assert property (@(posedge clk) disable iff (rst)
		source_valid && !source_ready |=> source_valid && $stable(source_real)
		&& $stable(source_imag) && $stable(source_sop) && $stable(source_eop)
		&& $stable(dftpts_out))
	else
	begin
		$error("source stream changed while stalled");
		fail_cnt++;
	end

	a_marks: assert property (@(posedge clk) disable iff (rst)
		(source_sop || source_eop) |-> source_valid)
	else
	begin
		$error("frame marker without source_valid");
		fail_cnt++;
	end

	// the input bank stays closed from a legal eop until the FSM takes the frame
	a_stall_hold: assert property (@(posedge clk) disable iff (rst)
		!sink_ready && !frame_taken |=> !sink_ready)
	else
	begin
		$error("sink_ready rose before the frame was taken");
		fail_cnt++;
	end

	// the FSM only idles once the previous frame has left the output bank
	a_idle_empty: assert property (@(posedge clk) disable iff (rst)
		ctrl_state == ST_IDLE |-> !source_valid)
	else
	begin
		$error("control FSM idle while the output stream is still busy");
		fail_cnt++;
	end

endmodule

bind mrd_top mrd_sva u_sva (
	.clk          (clk),
	.rst          (rst),
	.sink_ready   (sink_ready),
	.source_valid (source_valid),
	.source_ready (source_ready),
	.source_sop   (source_sop),
	.source_eop   (source_eop),
	.source_real  (source_real),
	.source_imag  (source_imag),
	.dftpts_out   (dftpts_out),
	.frame_taken  (frame_taken),
	.ctrl_state   (u_ctrl.state)
);

// ==== verif/mrd_tb.sv ====
// DFT engine testbench: frame table, reference DFT, output stream checks and report
`timescale 1ns/10ps
`include "mrd_cfg.svh"

module mrd_tb;
	import mrd_pkg::*;

	localparam int SEED = 20737;
	localparam int IMP_AMP = 77777;
	localparam int WAIT_MAX = 200;
	localparam int DRAIN_MAX = 4000;
	localparam real PI = 3.14159265358979;

	logic                         clk;
	logic                         rst;
	logic                         sink_valid;
	logic                         sink_ready;
	logic                         sink_sop;
	logic                         sink_eop;
	logic signed [`MRD_IN_W-1:0]  sink_real;
	logic signed [`MRD_IN_W-1:0]  sink_imag;
	logic [`MRD_PTS_W-1:0]        dftpts_in;
	logic                         inverse;
	logic                         source_valid;
	logic                         source_ready;
	logic                         source_sop;
	logic                         source_eop;
	logic signed [`MRD_OUT_W-1:0] source_real;
	logic signed [`MRD_OUT_W-1:0] source_imag;
	logic [`MRD_PTS_W-1:0]        dftpts_out;

	// frame table, one row per test; t_out says whether the frame must produce bins
	string t_name [$];
	int    t_pts  [$];
	bit    t_inv  [$];
	int    t_eop  [$];
	bit    t_rnd  [$];
	bit    t_bp   [$];
	bit    t_out  [$];

	// legal frames the DUT still owes, with their bins in output order
	int                           exp_test [$];
	logic signed [`MRD_OUT_W-1:0] exp_re   [$];
	logic signed [`MRD_OUT_W-1:0] exp_im   [$];
	logic signed [`MRD_IN_W-1:0]  smp_re   [8];
	logic signed [`MRD_IN_W-1:0]  smp_im   [8];

	int seed;
	int ready_seed;
	int head;
	int beat;
	int out_errs;
	int passed;
	int failed;
	int errors;
	bit timed_out;

	mrd_top u_dut (.*);

	always #4 clk = ~clk;

	task automatic add_test(input string name, input int pts, input bit inv, input int eop_pos,
		input bit rnd, input bit bp, input bit out);
		t_name.push_back(name);
		t_pts.push_back(pts);
		t_inv.push_back(inv);
		t_eop.push_back(eop_pos);
		t_rnd.push_back(rnd);
		t_bp.push_back(bp);
		t_out.push_back(out);
	endtask

	function automatic longint round_tw(input real x);
		if (x >= 0.0)
			return longint'($rtoi(x + 0.5));
		return -longint'($rtoi(0.5 - x));
	endfunction

	task automatic make_samples(input int idx);
		int i;
		for (i = 0; i < 8; i++)
		begin
			if (t_rnd[idx])
			begin
				smp_re[i] = `MRD_IN_W'($random(seed));
				smp_im[i] = `MRD_IN_W'($random(seed));
			end
			else
			begin
				// impulse at sample 0, real only
				smp_re[i] = (i == 0) ? `MRD_IN_W'(IMP_AMP) : '0;
				smp_im[i] = '0;
			end
		end
	endtask

	// direct DFT with rounded twiddles, sine negated for the forward transform
	task automatic push_model(input int idx);
		int     n_pts;
		int     k;
		int     n;
		longint acc_re;
		longint acc_im;
		longint c;
		longint s;
		real    ang;
		n_pts = t_pts[idx];
		exp_test.push_back(idx);
		for (k = 0; k < n_pts; k++)
		begin
			acc_re = 0;
			acc_im = 0;
			for (n = 0; n < n_pts; n++)
			begin
				ang = 2.0 * PI * real'((n * k) % n_pts) / real'(n_pts);
				c = round_tw(16384.0 * $cos(ang));
				s = round_tw(16384.0 * $sin(ang));
				if (!t_inv[idx])
					s = -s;
				acc_re += longint'(smp_re[n]) * c - longint'(smp_im[n]) * s;
				acc_im += longint'(smp_re[n]) * s + longint'(smp_im[n]) * c;
			end
			exp_re.push_back(`MRD_OUT_W'(acc_re >>> `MRD_OUT_SHIFT));
			exp_im.push_back(`MRD_OUT_W'(acc_im >>> `MRD_OUT_SHIFT));
		end
	endtask

	task automatic check_bin(input string name, input int k,
		input logic signed [`MRD_OUT_W-1:0] er, input logic signed [`MRD_OUT_W-1:0] ei,
		input logic signed [`MRD_OUT_W-1:0] ar, input logic signed [`MRD_OUT_W-1:0] ai);
		if (ar !== er || ai !== ei)
		begin
			$display("Fail %s bin %0d: expected (%0d, %0d), actual (%0d, %0d)",
				name, k, er, ei, ar, ai);
			out_errs++;
		end
	endtask

	task automatic check_pts(input string name, input logic [`MRD_PTS_W-1:0] ep,
		input logic [`MRD_PTS_W-1:0] ap);
		if (ap !== ep)
		begin
			$display("Fail %s dftpts_out: expected %0d, actual %0d", name, ep, ap);
			out_errs++;
		end
	endtask

	task automatic check_marks(input string name, input int k, input logic [1:0] em,
		input logic [1:0] am);
		if (am !== em)
		begin
			$display("Fail %s bin %0d sop/eop: expected %b, actual %b", name, k, em, am);
			out_errs++;
		end
	endtask

	task automatic finish_test(input string name, input int errs);
		if (errs == 0)
		begin
			passed++;
			$display("test %s: ok", name);
		end
		else
		begin
			failed++;
			$display("test %s: %0d mismatches", name, errs);
		end
	endtask

	// starts on a rising edge and ends on the edge that takes the last sample
	task automatic send_frame(input int idx);
		int i;
		int wait_cnt;
		for (i = 0; i <= t_eop[idx]; i++)
		begin
			sink_valid <= 1'b1;
			sink_sop <= (i == 0);
			sink_eop <= (i == t_eop[idx]);
			sink_real <= smp_re[i];
			sink_imag <= smp_im[i];
			dftpts_in <= (i == 0) ? `MRD_PTS_W'(t_pts[idx]) : '0;
			inverse <= (i == 0) ? t_inv[idx] : 1'b0;
			wait_cnt = 0;
			@(negedge clk);
			while (!sink_ready)
			begin
				wait_cnt++;
				if (wait_cnt > WAIT_MAX)
				begin
					$display("timeout: %s sample %0d was never accepted", t_name[idx], i);
					timed_out = 1'b1;
					return;
				end
				@(negedge clk);
			end
			@(posedge clk);
		end
	endtask

	// back-pressure follows the frame at the head of the output
	always @(posedge clk)
	begin
		if (exp_test.size() > 0 && t_bp[exp_test[0]])
			source_ready <= 1'($random(ready_seed));
		else
			source_ready <= 1'b1;
	end

	// a beat seen at the falling edge moves on the next rising edge
	always @(negedge clk)
	begin
		if (!rst && source_valid && source_ready)
		begin
			if (exp_test.size() == 0)
			begin
				$display("output beat arrived with no legal frame pending");
				errors++;
			end
			else
			begin
				head = exp_test[0];
				if (beat == 0)
					out_errs = 0;
				check_bin(t_name[head], beat, exp_re.pop_front(), exp_im.pop_front(),
					source_real, source_imag);
				check_pts(t_name[head], `MRD_PTS_W'(t_pts[head]), dftpts_out);
				check_marks(t_name[head], beat, {beat == 0, beat == t_pts[head] - 1},
					{source_sop, source_eop});
				if (beat == t_pts[head] - 1)
				begin
					finish_test(t_name[head], out_errs);
					void'(exp_test.pop_front());
					beat = 0;
				end
				else
					beat++;
			end
		end
	end

	initial
	begin
		int t;
		int drain;
		int drop_errs;
		clk = 1'b0;
		rst = 1'b1;
		sink_valid = 1'b0;
		sink_sop = 1'b0;
		sink_eop = 1'b0;
		sink_real = '0;
		sink_imag = '0;
		dftpts_in = '0;
		inverse = 1'b0;
		source_ready = 1'b1;
		seed = SEED;
		ready_seed = SEED;
		beat = 0;
		out_errs = 0;
		passed = 0;
		failed = 0;
		errors = 0;
		timed_out = 1'b0;
		// name, points, inverse, eop position, random samples, back-pressure, output expected
		add_test("fwd_n2", 2, 0, 1, 1, 0, 1);
		add_test("fwd_n3", 3, 0, 2, 1, 0, 1);
		add_test("fwd_n4", 4, 0, 3, 1, 0, 1);
		add_test("fwd_n5", 5, 0, 4, 1, 0, 1);
		add_test("inv_n3", 3, 1, 2, 1, 0, 1);
		add_test("inv_n5", 5, 1, 4, 1, 0, 1);
		add_test("impulse_n4", 4, 0, 3, 0, 0, 1);
		add_test("impulse_n5", 5, 0, 4, 0, 0, 1);
		add_test("bad_pts6", 6, 0, 5, 1, 0, 0);
		add_test("after_pts6", 4, 0, 3, 1, 0, 1);
		add_test("early_eop", 4, 0, 2, 1, 0, 0);
		add_test("after_early", 5, 1, 4, 1, 0, 1);
		add_test("bp_n5", 5, 0, 4, 1, 1, 1);
		add_test("bp_n3", 3, 1, 2, 1, 1, 1);
		add_test("bp_n4", 4, 0, 3, 1, 1, 1);
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		for (t = 0; t < t_name.size() && !timed_out; t++)
		begin
			make_samples(t);
			if (t_out[t])
				push_model(t);
			send_frame(t);
			if (!t_out[t] && !timed_out)
			begin
				// a dropped frame never closes the input bank
				sink_valid <= 1'b0;
				@(negedge clk);
				drop_errs = 0;
				if (!sink_ready)
				begin
					$display("Fail %s sink_ready: expected 1, actual 0", t_name[t]);
					drop_errs++;
				end
				finish_test(t_name[t], drop_errs);
				@(posedge clk);
			end
		end
		sink_valid <= 1'b0;
		sink_sop <= 1'b0;
		sink_eop <= 1'b0;
		drain = 0;
		while (exp_test.size() > 0 && !timed_out)
		begin
			@(negedge clk);
			drain++;
			if (drain > DRAIN_MAX)
			begin
				$display("timeout: %0d expected output frames never arrived", exp_test.size());
				timed_out = 1'b1;
			end
		end
		if (u_dut.u_sva.fail_cnt > 0)
		begin
			$display("%0d protocol assertions failed", u_dut.u_sva.fail_cnt);
			errors += u_dut.u_sva.fail_cnt;
		end
		$display("tests run %0d, passed %0d, failed %0d, other errors %0d",
			passed + failed, passed, failed, errors);
		if (failed == 0 && errors == 0 && !timed_out)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
